//--- bench/cpu_patterns.mem
// first entry: program length N
// then N entries: instruction word (upper 32 bits), expected write data (lower 32 bits)
0000000000000013
4411234500012345 // movi r1, 0x12345
44280001fff80001 // movi r2, 0x80001
5030810000012445 // addi r3, r1, 0x100
5040fffb00012340 // addi r4, r1, -5
40508800fff92346 // add r5, r1, r2
40608c01ffffff00 // sub r6, r1, r3
40711402fff80000 // and r7, r2, r5
40809804ffffff45 // or r8, r1, r6
40910403fff92344 // xor r9, r2, r1
4000000900000000 // nop
40a110090fff8000 // srli r10, r2, 4
40b0a00801234500 // slli r11, r1, 8
40c0900b50001234 // rotri r12, r1, 4
40d1040bfffc0000 // rotri r13, r2, 1
58e0c00000016345 // ori r14, r1, 0x4000
56f17ffffff87ffe // xori r15, r2, 0x7fff
4100fc0880000000 // slli r16, r1, 31
41100401fffedcbb // sub r17, r0, r1
4031900000024785 // add r3, r3, r4

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  import cpu_pkg::*;

  localparam int mem_size  = 10;
  localparam int max_words = 64;
  localparam int hs_limit  = 8;

  logic                clock;
  logic                reset;
  logic                run;
  logic                load_req;
  logic [mem_size-1:0] load_addr;
  word_t               load_data;
  logic                load_ack;
  logic [mem_size-1:0] pc;
  logic                wb_valid;
  reg_addr_t           wb_addr;
  word_t               wb_data;

  // entry 0 is the count, then {instruction, expected data}
  logic [63:0] patterns [0:max_words];
  word_t       nop_enc;
  int          n_instr;
  int          wb_seen = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  cpu_top #(
    .mem_size(mem_size)
  ) i_cpu_top (
    .clock     (clock),
    .reset     (reset),
    .run       (run),
    .load_req  (load_req),
    .load_addr (load_addr),
    .load_data (load_data),
    .load_ack  (load_ack),
    .pc        (pc),
    .wb_valid  (wb_valid),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic compare_reg_addr(input string name, input reg_addr_t got,
                                  input reg_addr_t exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic compare_pc(input string name, input logic [mem_size-1:0] got,
                            input logic [mem_size-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // srli r0, r0, 0
  function automatic word_t nop_encoding();
    instr_u u;
    u.basic.spare  = 1'b0;
    u.basic.opcode = op_basic;
    u.basic.rt     = '0;
    u.basic.ra     = '0;
    u.basic.rb     = '0;
    u.basic.rsvd   = '0;
    u.basic.sub    = sub_srli;
    return u;
  endfunction

  // one four-phase transfer into instruction memory
  task automatic load_word(input int addr, input word_t data);
    int waited;
    @(posedge clock);
    load_req  <= 1'b1;
    load_addr <= addr[mem_size-1:0];
    load_data <= data;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (load_ack !== 1'b1 && waited < hs_limit);
    if (load_ack !== 1'b1) begin
      report_error($sformatf("load_ack did not rise within %0d cycles at address %0d",
                             hs_limit, addr));
    end
    load_req <= 1'b0;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (load_ack !== 1'b0 && waited < hs_limit);
    if (load_ack !== 1'b0) begin
      report_error($sformatf("load_ack did not fall within %0d cycles at address %0d",
                             hs_limit, addr));
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      report_error($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    instr_u              dec;
    logic [mem_size-1:0] exp_pc;
    int                  next_idx;
    int                  prev_idx;
    int                  last_wb_cycle;
    int                  nops;

    reset     = 1'b1;
    run       = 1'b0;
    load_req  = 1'b0;
    load_addr = '0;
    load_data = '0;
    nop_enc   = nop_encoding();

    $readmemh("bench/cpu_patterns.mem", patterns);
    n_instr = patterns[0][31:0];
    if (n_instr < 1 || n_instr > max_words) begin
      report_error($sformatf("pattern file gives a bad program length of %0d", n_instr));
    end
    cycle_limit = 40 * n_instr + 200;

    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    compare_flag("load_ack", load_ack, 1'b0);
    compare_flag("wb_valid", wb_valid, 1'b0);
    compare_pc("pc", pc, '0);

    for (int i = 0; i < n_instr; i++) begin
      load_word(i, patterns[i + 1][63:32]);
    end

    @(posedge clock);
    run <= 1'b1;
    next_idx      = 0;
    prev_idx      = -1;
    last_wb_cycle = 0;
    // write cycle of instruction i is sampled at cycle 4 * (i + 1)
    for (int cyc = 1; cyc <= 4 * n_instr; cyc++) begin
      @(posedge clock);
      if (wb_valid === 1'b1) begin
        while (next_idx < n_instr && patterns[next_idx + 1][63:32] == nop_enc) begin
          next_idx++;
        end
        if (next_idx >= n_instr) begin
          report_error("wb_valid pulsed with no instruction left to write back");
        end
        dec    = patterns[next_idx + 1][63:32];
        exp_pc = next_idx[mem_size-1:0];
        compare_pc("pc", pc, exp_pc);
        compare_reg_addr("wb_addr", wb_addr, dec.mov.rt);
        compare_word("wb_data", wb_data, patterns[next_idx + 1][31:0]);
        if (cyc - last_wb_cycle != 4 * (next_idx - prev_idx)) begin
          report_error($sformatf("writeback came %0d cycles after the previous one, not %0d",
                                 cyc - last_wb_cycle, 4 * (next_idx - prev_idx)));
        end
        last_wb_cycle = cyc;
        prev_idx      = next_idx;
        next_idx++;
        wb_seen++;
      end else begin
        compare_flag("wb_valid", wb_valid, 1'b0);
      end
      // pc steps to N on this edge
      if (cyc == 4 * n_instr) begin
        run <= 1'b0;
      end
    end

    // idle with run low
    exp_pc = n_instr[mem_size-1:0];
    repeat (6) begin
      @(posedge clock);
      compare_flag("wb_valid", wb_valid, 1'b0);
      compare_pc("pc", pc, exp_pc);
    end

    nops = 0;
    for (int i = 0; i < n_instr; i++) begin
      if (patterns[i + 1][63:32] == nop_enc) begin
        nops++;
      end
    end

    if (wb_seen != n_instr - nops) begin
      report_error($sformatf("saw %0d writebacks, expected %0d", wb_seen, n_instr - nops));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module cpu_tb -f verilog.f -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test passed" sim.log; then
  exit 0
fi
exit 1

//--- verilog.f
verilog/cpu_pkg.sv
verilog/ir_controller.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/cpu_top.sv
bench/cpu_tb.sv

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcode, bits 30:25
  typedef enum logic [5:0] {
    op_basic = 6'b100000,
    op_movi  = 6'b100010,
    op_addi  = 6'b101000,
    op_xori  = 6'b101011,
    op_ori   = 6'b101100
  } opcode_t;

  // basic group sub-opcode, bits 4:0
  typedef enum logic [4:0] {
    sub_add   = 5'b00000,
    sub_sub   = 5'b00001,
    sub_and   = 5'b00010,
    sub_xor   = 5'b00011,
    sub_or    = 5'b00100,
    sub_slli  = 5'b01000,
    sub_srli  = 5'b01001,
    sub_rotri = 5'b01011
  } sub_op_t;

  typedef enum logic [1:0] {
    st_stop  = 2'b00,
    st_fetch = 2'b01,
    st_exe   = 2'b10,
    st_write = 2'b11
  } ctrl_state_t;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_t;

  typedef enum logic {
    wb_alu = 1'b0,
    wb_imm = 1'b1
  } wb_sel_t;

  typedef enum logic {
    opnd_reg = 1'b0,
    opnd_imm = 1'b1
  } opnd_sel_t;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic       spare;
      opcode_t    opcode;
      reg_addr_t  rt;
      reg_addr_t  ra;
      reg_addr_t  rb;
      logic [4:0] rsvd;
      sub_op_t    sub;
    } basic;
    struct packed {
      logic        spare;
      opcode_t     opcode;
      reg_addr_t   rt;
      reg_addr_t   ra;
      logic [14:0] imm15;
    } imm;
    struct packed {
      logic        spare;
      opcode_t     opcode;
      reg_addr_t   rt;
      logic [19:0] imm20;
    } mov;
  } instr_u;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int mem_size = 10
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                run,
  input  logic                load_req,
  input  logic [mem_size-1:0] load_addr,
  input  cpu_pkg::word_t      load_data,
  output logic                load_ack,
  output logic [mem_size-1:0] pc,
  output logic                wb_valid,
  output cpu_pkg::reg_addr_t  wb_addr,
  output cpu_pkg::word_t      wb_data
);

  import cpu_pkg::*;

  logic        im_read;
  word_t       instr_word;
  logic        rd_en;
  reg_addr_t   ra_addr;
  reg_addr_t   rb_addr;
  word_t       ra_data;
  word_t       rb_data;
  logic        alu_en;
  opcode_t     opcode;
  sub_op_t     sub_op;
  logic [4:0]  imm5;
  logic [14:0] imm15;
  logic [19:0] imm20;
  imm_sel_t    imm_sel;
  opnd_sel_t   opnd_sel;
  wb_sel_t     wb_sel;

  ir_controller #(
    .mem_size(mem_size)
  ) i_ir_controller (
    .clock      (clock),
    .reset      (reset),
    .run        (run),
    .instr_word (instr_word),
    .pc         (pc),
    .im_read    (im_read),
    .rd_en      (rd_en),
    .ra_addr    (ra_addr),
    .rb_addr    (rb_addr),
    .alu_en     (alu_en),
    .opcode     (opcode),
    .sub_op     (sub_op),
    .imm5       (imm5),
    .imm15      (imm15),
    .imm20      (imm20),
    .imm_sel    (imm_sel),
    .opnd_sel   (opnd_sel),
    .wb_sel     (wb_sel),
    .wr_en      (wb_valid),
    .wr_addr    (wb_addr)
  );

  instr_mem #(
    .mem_size(mem_size)
  ) i_instr_mem (
    .clock      (clock),
    .reset      (reset),
    .load_req   (load_req),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .load_ack   (load_ack),
    .im_read    (im_read),
    .pc         (pc),
    .instr_word (instr_word)
  );

  // writeback port doubles as the observation outputs
  reg_file i_reg_file (
    .clock   (clock),
    .reset   (reset),
    .rd_en   (rd_en),
    .ra_addr (ra_addr),
    .rb_addr (rb_addr),
    .wr_en   (wb_valid),
    .wr_addr (wb_addr),
    .wr_data (wb_data),
    .ra_data (ra_data),
    .rb_data (rb_data)
  );

  exec_unit i_exec_unit (
    .clock    (clock),
    .reset    (reset),
    .alu_en   (alu_en),
    .opcode   (opcode),
    .sub_op   (sub_op),
    .imm5     (imm5),
    .imm15    (imm15),
    .imm20    (imm20),
    .imm_sel  (imm_sel),
    .opnd_sel (opnd_sel),
    .wb_sel   (wb_sel),
    .ra_data  (ra_data),
    .rb_data  (rb_data),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  logic               clock,
  input  logic               reset,
  input  logic               alu_en,
  input  cpu_pkg::opcode_t   opcode,
  input  cpu_pkg::sub_op_t   sub_op,
  input  logic [4:0]         imm5,
  input  logic [14:0]        imm15,
  input  logic [19:0]        imm20,
  input  cpu_pkg::imm_sel_t  imm_sel,
  input  cpu_pkg::opnd_sel_t opnd_sel,
  input  cpu_pkg::wb_sel_t   wb_sel,
  input  cpu_pkg::word_t     ra_data,
  input  cpu_pkg::word_t     rb_data,
  output cpu_pkg::word_t     wb_data
);

  import cpu_pkg::*;

  word_t       imm_ext;
  word_t       opnd_b;
  word_t       alu_result;
  logic [4:0]  shamt;
  logic [63:0] rot_wide;

  always_comb begin
    case (imm_sel)
      imm5_ze:  imm_ext = {27'b0, imm5};
      imm15_se: imm_ext = {{17{imm15[14]}}, imm15};
      imm15_ze: imm_ext = {17'b0, imm15};
      imm20_se: imm_ext = {{12{imm20[19]}}, imm20};
      default:  imm_ext = '0;
    endcase
  end

  assign opnd_b = (opnd_sel == opnd_imm) ? imm_ext : rb_data;
  assign shamt  = opnd_b[4:0];

  // rotate right via a doubled word
  assign rot_wide = {ra_data, ra_data} >> shamt;

  always_comb begin
    alu_result = '0;
    case (opcode)
      op_basic: begin
        case (sub_op)
          sub_add:   alu_result = ra_data + opnd_b;
          sub_sub:   alu_result = ra_data - opnd_b;
          sub_and:   alu_result = ra_data & opnd_b;
          sub_or:    alu_result = ra_data | opnd_b;
          sub_xor:   alu_result = ra_data ^ opnd_b;
          sub_srli:  alu_result = ra_data >> shamt;
          sub_slli:  alu_result = ra_data << shamt;
          sub_rotri: alu_result = rot_wide[31:0];
          default:   alu_result = '0;
        endcase
      end
      op_addi: alu_result = ra_data + opnd_b;
      op_ori:  alu_result = ra_data | opnd_b;
      op_xori: alu_result = ra_data ^ opnd_b;
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_data <= '0;
    end else if (alu_en) begin
      wb_data <= (wb_sel == wb_imm) ? imm_ext : alu_result;
    end
  end

endmodule

`default_nettype wire

//--- verilog/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
  parameter int mem_size = 10
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                load_req,
  input  logic [mem_size-1:0] load_addr,
  input  cpu_pkg::word_t      load_data,
  output logic                load_ack,
  input  logic                im_read,
  input  logic [mem_size-1:0] pc,
  output cpu_pkg::word_t      instr_word
);

  import cpu_pkg::*;

  localparam int depth = 1 << mem_size;

  word_t mem [0:depth-1];
  logic  load_we;

  // new request seen while ack is still low
  assign load_we = load_req && !load_ack;

  // four-phase responder
  always_ff @(posedge clock) begin
    if (reset) begin
      load_ack <= 1'b0;
    end else if (load_we) begin
      load_ack <= 1'b1;
    end else if (!load_req && load_ack) begin
      load_ack <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (im_read) begin
      instr_word <= mem[pc];
    end
  end

endmodule

`default_nettype wire

//--- verilog/ir_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ir_controller #(
  parameter int mem_size = 10
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                run,
  input  cpu_pkg::word_t      instr_word,
  output logic [mem_size-1:0] pc,
  output logic                im_read,
  output logic                rd_en,
  output cpu_pkg::reg_addr_t  ra_addr,
  output cpu_pkg::reg_addr_t  rb_addr,
  output logic                alu_en,
  output cpu_pkg::opcode_t    opcode,
  output cpu_pkg::sub_op_t    sub_op,
  output logic [4:0]          imm5,
  output logic [14:0]         imm15,
  output logic [19:0]         imm20,
  output cpu_pkg::imm_sel_t   imm_sel,
  output cpu_pkg::opnd_sel_t  opnd_sel,
  output cpu_pkg::wb_sel_t    wb_sel,
  output logic                wr_en,
  output cpu_pkg::reg_addr_t  wr_addr
);

  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  instr_u      fetch_u;
  instr_u      ir_q;
  logic        is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_stop;
    end else begin
      state <= state_next;
    end
  end

  // an instruction, once started, always runs to the end of st_write
  always_comb begin
    case (state)
      st_stop:  state_next = run ? st_fetch : st_stop;
      st_fetch: state_next = st_exe;
      st_exe:   state_next = st_write;
      default:  state_next = st_stop;
    endcase
  end

  // memory word is valid during st_fetch
  assign fetch_u = instr_word;

  always_ff @(posedge clock) begin
    if (state == st_fetch) begin
      ir_q <= instr_word;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (state == st_write) begin
      pc <= pc + 1'b1;
    end
  end

  // register reads use the word straight from memory
  assign ra_addr = fetch_u.basic.ra;
  assign rb_addr = fetch_u.basic.rb;

  assign opcode  = ir_q.basic.opcode;
  assign sub_op  = ir_q.basic.sub;
  assign imm5    = ir_q.basic.rb;
  assign imm15   = ir_q.imm.imm15;
  assign imm20   = ir_q.mov.imm20;
  assign wr_addr = ir_q.mov.rt;

  // srli r0, r0, 0
  assign is_nop = (ir_q.basic.opcode == op_basic) && (ir_q.basic.sub == sub_srli) &&
                  (ir_q.basic.rt == '0) && (ir_q.basic.ra == '0) && (ir_q.basic.rb == '0);

  assign im_read = (state == st_stop) && run;
  assign rd_en   = (state == st_fetch);
  assign alu_en  = (state == st_exe);
  assign wr_en   = (state == st_write) && !is_nop;

  always_comb begin
    imm_sel  = imm5_ze;
    opnd_sel = opnd_reg;
    wb_sel   = wb_alu;
    case (ir_q.basic.opcode)
      op_basic: begin
        if (ir_q.basic.sub inside {sub_srli, sub_slli, sub_rotri}) begin
          opnd_sel = opnd_imm;
        end
      end
      op_addi: begin
        imm_sel  = imm15_se;
        opnd_sel = opnd_imm;
      end
      op_ori, op_xori: begin
        imm_sel  = imm15_ze;
        opnd_sel = opnd_imm;
      end
      op_movi: begin
        imm_sel  = imm20_se;
        opnd_sel = opnd_imm;
        wb_sel   = wb_imm;
      end
      default: begin
        imm_sel = imm5_ze;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  logic               rd_en,
  input  cpu_pkg::reg_addr_t ra_addr,
  input  cpu_pkg::reg_addr_t rb_addr,
  input  logic               wr_en,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::word_t     wr_data,
  output cpu_pkg::word_t     ra_data,
  output cpu_pkg::word_t     rb_data
);

  import cpu_pkg::*;

  word_t regs [0:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // reads and writes never share a cycle in this core
  always_ff @(posedge clock) begin
    if (rd_en) begin
      ra_data <= regs[ra_addr];
      rb_data <= regs[rb_addr];
    end
  end

endmodule

`default_nettype wire
